// File: tb.f
design/memPkg.sv
design/clearCounter.sv
design/laneSteer.sv
design/wordRam.sv
design/busCtrlFsm.sv
design/dataMem.sv
dv/dataMem_chk.sv
dv/dataMemTb.sv

// File: Makefile
# Verilator build for the data memory testbench
# sim exits non-zero when the testbench stops with $fatal

TOP := dataMemTb
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module dataMem
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -Mdir $(OBJ) -o simv \
		-f tb.f --top-module $(TOP)
	./$(OBJ)/simv

clean:
	rm -rf $(OBJ)

// File: dv/dataMemTb.sv
// ======================================================================
// testbench for the data memory with clock, reset, LFSR, reference
// model, Wishbone bus tasks, compare tasks and directed tests
// ======================================================================
`default_nettype none

module dataMemTb;

  import memPkg::*;

  logic        clk;
  logic        rstN;
  wbReqT       wbReq;
  wbRspT       wbRsp;
  logic [31:0] lfsrState;
  // reference copy of the zero cleared array
  logic [31:0] refMem [MemWords];

  dataMem i_dataMem (
    .clk   (clk),
    .rstN  (rstN),
    .wbReq (wbReq),
    .wbRsp (wbRsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Fibonacci form with taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  // alignment rule per size tag
  function automatic logic isLegal(input accessSizeE size, input logic [1:0] off);
    case (size)
      sizeByte: return 1'b1;
      sizeHalf: return off[0] == 1'b0;
      sizeWord: return off == 2'b00;
      default:  return 1'b0;
    endcase
  endfunction

  // is byte lane k touched by this access
  function automatic logic laneOn(input accessSizeE size, input logic [1:0] off, input int k);
    logic [1:0] lane;
    lane = 2'(k);
    case (size)
      sizeByte: return lane == off;
      sizeHalf: return lane[1] == off[1];
      sizeWord: return 1'b1;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic void modelWrite(input logic [AdrW-1:0] adr, input accessSizeE size,
                                     input logic [31:0] dat);
    logic [WordIdxW-1:0] idx;
    idx = adr[AdrW-1:2];
    for (int k = 0; k < 4; k++) begin
      if (laneOn(size, adr[1:0], k)) begin
        refMem[idx][8*k +: 8] = dat[8*k +: 8];
      end
    end
  endfunction

  task automatic failNow(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkRsp(input wbRspT got, input wbRspT exp);
    if (got.ack !== exp.ack || got.err !== exp.err) begin
      failNow($sformatf("Mismatch wbRsp.ack/err: got 0x%0h/0x%0h expected 0x%0h/0x%0h",
                        got.ack, got.err, exp.ack, exp.err));
    end
  endtask

  task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      failNow($sformatf("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // one classic cycle entered and left 1 unit after a rising edge
  task automatic busCycle(input logic we, input logic [AdrW-1:0] adr, input accessSizeE size,
                          input logic [31:0] dat, output wbRspT rsp);
    int waited;
    wbReq.cyc  = 1'b1;
    wbReq.stb  = 1'b1;
    wbReq.we   = we;
    wbReq.adr  = adr;
    wbReq.size = size;
    wbReq.dat  = dat;
    waited = 0;
    rsp = '0;
    // long enough to cover the clear sweep
    while (rsp.ack !== 1'b1 && rsp.err !== 1'b1) begin
      if (waited == 2 * MemWords) begin
        failNow("no ack or err came back within the response timeout");
      end
      @(posedge clk);
      #1;
      rsp = wbRsp;
      waited++;
    end
    wbReq.cyc = 1'b0;
    wbReq.stb = 1'b0;
    if (rsp.ack === 1'b1 && rsp.err === 1'b1) begin
      failNow("ack and err were both high for one request");
    end
    // let the response cycle end
    @(posedge clk);
    #1;
  endtask

  task automatic wbWrite(input logic [AdrW-1:0] adr, input accessSizeE size,
                         input logic [31:0] dat);
    wbRspT rsp;
    wbRspT exp;
    logic  legal;
    legal = isLegal(size, adr[1:0]);
    busCycle(1'b1, adr, size, dat, rsp);
    exp = '0;
    exp.ack = legal;
    exp.err = !legal;
    checkRsp(rsp, exp);
    if (legal) begin
      modelWrite(adr, size, dat);
    end
  endtask

  task automatic wbRead(input logic [AdrW-1:0] adr, input accessSizeE size);
    wbRspT rsp;
    wbRspT exp;
    logic  legal;
    legal = isLegal(size, adr[1:0]);
    busCycle(1'b0, adr, size, 32'h0, rsp);
    exp = '0;
    exp.ack = legal;
    exp.err = !legal;
    checkRsp(rsp, exp);
    // whole word back for any size
    if (legal) begin
      checkWord("wbRsp.dat", rsp.dat, refMem[adr[AdrW-1:2]]);
    end
  endtask

  task automatic zeroClearReads();
    logic [WordIdxW-1:0] idx;
    // first request sits through the sweep
    wbRead({WordIdxW'(0), 2'b00}, sizeWord);
    wbRead({WordIdxW'(MemWords - 1), 2'b00}, sizeWord);
    for (int i = 0; i < 6; i++) begin
      idx = WordIdxW'(randBits(WordIdxW));
      wbRead({idx, 2'b00}, sizeWord);
    end
  endtask

  task automatic wordReadback();
    logic [WordIdxW-1:0] idx;
    logic [31:0]         dat;
    for (int i = 0; i < 12; i++) begin
      idx = WordIdxW'(randBits(WordIdxW));
      dat = randBits(32);
      wbWrite({idx, 2'b00}, sizeWord, dat);
      wbRead({idx, 2'b00}, sizeWord);
    end
  endtask

  task automatic byteLaneWrites();
    logic [WordIdxW-1:0] idx;
    idx = WordIdxW'(8'h2c);
    wbWrite({idx, 2'b00}, sizeWord, 32'h1234_5678);
    // other lanes carry junk that must not land
    for (int k = 0; k < 4; k++) begin
      wbWrite({idx, 2'(k)}, sizeByte, randBits(32));
      wbRead({idx, 2'b00}, sizeWord);
    end
  endtask

  task automatic halfWordWrites();
    logic [WordIdxW-1:0] idx;
    idx = WordIdxW'(8'h71);
    wbWrite({idx, 2'b00}, sizeWord, 32'hcafe_d00d);
    wbWrite({idx, 2'b00}, sizeHalf, randBits(32));
    wbRead({idx, 2'b00}, sizeWord);
    wbWrite({idx, 2'b10}, sizeHalf, randBits(32));
    wbRead({idx, 2'b00}, sizeWord);
  endtask

  task automatic illegalAccesses();
    logic [WordIdxW-1:0] idx;
    idx = WordIdxW'(8'h9e);
    wbWrite({idx, 2'b00}, sizeWord, 32'h0bad_beef);
    // odd halfword, offset word, reserved size
    wbWrite({idx, 2'b01}, sizeHalf, randBits(32));
    wbWrite({idx, 2'b11}, sizeHalf, randBits(32));
    wbWrite({idx, 2'b10}, sizeWord, randBits(32));
    wbWrite({idx, 2'b00}, sizeRsvd, randBits(32));
    wbRead({idx, 2'b00}, sizeRsvd);
    wbRead({idx, 2'b01}, sizeWord);
    // word must still hold the known value
    wbRead({idx, 2'b00}, sizeWord);
  endtask

  task automatic mixedAccesses();
    logic [31:0]     pick;
    logic            we;
    accessSizeE      size;
    logic [AdrW-1:0] adr;
    logic [31:0]     dat;
    int              gap;
    for (int i = 0; i < 64; i++) begin
      pick = randBits(1);
      we   = pick[0];
      size = accessSizeE'(randBits(2));
      adr  = AdrW'(randBits(AdrW));
      dat  = randBits(32);
      gap  = int'(randBits(2));
      if (we) begin
        wbWrite(adr, size, dat);
      end else begin
        wbRead(adr, size);
      end
      // idle gap of 0 to 3 cycles
      for (int g = 0; g < gap; g++) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  // a protocol flag from the bound checker ends the run at the next edge
  always @(posedge clk) begin
    if (i_dataMem.i_dataMemChk.failBoth || i_dataMem.i_dataMemChk.failTwice ||
        i_dataMem.i_dataMemChk.failOrphan) begin
      failNow("a Wishbone protocol assertion in the checker failed");
    end
  end

  initial begin
    rstN      = 1'b0;
    wbReq     = '0;
    lfsrState = 32'h49c7;
    for (int i = 0; i < MemWords; i++) begin
      refMem[i] = 32'h0;
    end
    repeat (3) @(posedge clk);
    #1;
    rstN = 1'b1;
    zeroClearReads();
    wordReadback();
    byteLaneWrites();
    halfWordWrites();
    illegalAccesses();
    mixedAccesses();
    if (i_dataMem.i_dataMemChk.failBoth || i_dataMem.i_dataMemChk.failTwice ||
        i_dataMem.i_dataMemChk.failOrphan) begin
      failNow("a Wishbone protocol assertion in the checker failed");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule : dataMemTb

`default_nettype wire

// File: dv/dataMem_chk.sv
// ======================================================================
// Wishbone response assertions, bound into the data memory top
// ======================================================================
`default_nettype none

module dataMemChk (
  input logic          clk,
  input logic          rstN,
  input memPkg::wbReqT wbReq,
  input memPkg::wbRspT wbRsp
);

  logic rspAny;
  // sticky flags, one per property
  logic failBoth;
  logic failTwice;
  logic failOrphan;

  assign rspAny = wbRsp.ack | wbRsp.err;

  initial begin
    failBoth   = 1'b0;
    failTwice  = 1'b0;
    failOrphan = 1'b0;
  end

  // one kind of answer per request
  ackErrExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(wbRsp.ack && wbRsp.err))
    else begin
      $error("ack and err high in the same cycle");
      failBoth = 1'b1;
    end

  // single cycle response
  rspOneCycle: assert property (@(posedge clk) disable iff (!rstN)
    rspAny |=> !rspAny)
    else begin
      $error("ack or err held for two cycles");
      failTwice = 1'b1;
    end

  // a response needs a strobed request one edge before
  rspNeedsStb: assert property (@(posedge clk) disable iff (!rstN)
    rspAny |-> $past(wbReq.cyc && wbReq.stb))
    else begin
      $error("ack or err without stb in the previous cycle");
      failOrphan = 1'b1;
    end

endmodule : dataMemChk

bind dataMem dataMemChk i_dataMemChk (
  .clk   (clk),
  .rstN  (rstN),
  .wbReq (wbReq),
  .wbRsp (wbRsp)
);

`default_nettype wire

// File: design/dataMem.sv
// ======================================================================
// data memory top: Wishbone slave port around the lane decode,
// clear counter, word RAM and bus control FSM
// ======================================================================
`default_nettype none

module dataMem (
  input  logic          clk,
  input  logic          rstN,
  input  memPkg::wbReqT wbReq,
  output memPkg::wbRspT wbRsp
);

  import memPkg::*;

  // decoded lanes and legality
  laneCtlT             laneCtl;
  logic                accessOk;
  // clear sweep
  logic                clearEn;
  logic                clearDone;
  logic [WordIdxW-1:0] clearIdx;
  // RAM strobes and read word
  logic                ramWrEn;
  logic                ramRdEn;
  logic [31:0]         ramRdData;

  // alignment is judged here and nowhere else
  laneSteer i_laneSteer (
    .wbReq    (wbReq),
    .laneCtl  (laneCtl),
    .accessOk (accessOk)
  );

  clearCounter i_clearCounter (
    .clk       (clk),
    .rstN      (rstN),
    .clearEn   (clearEn),
    .clearIdx  (clearIdx),
    .clearDone (clearDone)
  );

  wordRam #(
    .Depth (MemWords)
  ) i_wordRam (
    .clk      (clk),
    .clearEn  (clearEn),
    .clearIdx (clearIdx),
    .laneCtl  (laneCtl),
    .wrEn     (ramWrEn),
    .rdEn     (ramRdEn),
    .rdData   (ramRdData)
  );

  busCtrlFsm i_busCtrlFsm (
    .clk       (clk),
    .rstN      (rstN),
    .wbReq     (wbReq),
    .accessOk  (accessOk),
    .clearDone (clearDone),
    .ramRdData (ramRdData),
    .clearEn   (clearEn),
    .ramWrEn   (ramWrEn),
    .ramRdEn   (ramRdEn),
    .wbRsp     (wbRsp)
  );

endmodule : dataMem

`default_nettype wire

// File: design/busCtrlFsm.sv
// ======================================================================
// Wishbone classic slave FSM: clear after reset, accept a single
// cycle request, answer with ack or err one cycle later
// ======================================================================
`default_nettype none

module busCtrlFsm (
  input  logic          clk,
  input  logic          rstN,
  input  memPkg::wbReqT wbReq,
  input  logic          accessOk,
  input  logic          clearDone,
  input  logic [31:0]   ramRdData,
  output logic          clearEn,
  output logic          ramWrEn,
  output logic          ramRdEn,
  output memPkg::wbRspT wbRsp
);

  // clearing holds off the bus until the array is zero
  typedef enum logic [1:0] {
    stClearing = 2'b00,
    stIdle     = 2'b01,
    stRespond  = 2'b10
  } stateE;

  stateE stateQ;
  stateE stateD;
  logic  ackQ;
  logic  errQ;
  logic  reqValid;
  logic  accept;

  // a request is live while both cyc and stb are up
  assign reqValid = wbReq.cyc & wbReq.stb;
  // only sampled in idle
  assign accept = (stateQ == stIdle) && reqValid;

  // sweep runs straight out of reset
  assign clearEn = (stateQ == stClearing);

  // RAM strobes for legal accesses only
  // write commits and read captures on the accept edge
  assign ramWrEn = accept & wbReq.we & accessOk;
  assign ramRdEn = accept & ~wbReq.we & accessOk;

  // next state
  always_comb begin
    stateD = stateQ;
    unique case (stateQ)
      stClearing: begin
        // last word is written on this edge
        if (clearDone) stateD = stIdle;
      end
      stIdle: begin
        if (reqValid) stateD = stRespond;
      end
      stRespond: begin
        // one response cycle, then back to idle
        stateD = stIdle;
      end
      default: begin
        stateD = stClearing;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stateQ <= stClearing;
      ackQ   <= 1'b0;
      errQ   <= 1'b0;
    end else begin
      stateQ <= stateD;
      // response lines are high for exactly the respond cycle
      // err covers misaligned and reserved size requests
      ackQ   <= accept & accessOk;
      errQ   <= accept & ~accessOk;
    end
  end

  assign wbRsp.ack = ackQ;
  assign wbRsp.err = errQ;
  // registered RAM word, meaningful only with ack on a read
  assign wbRsp.dat = ramRdData;

endmodule : busCtrlFsm

`default_nettype wire

// File: design/wordRam.sv
// ======================================================================
// word array with per byte write enables, registered read
// and a zero clear write port
// ======================================================================
`default_nettype none

module wordRam #(
  parameter int Depth = memPkg::MemWords
) (
  input  logic                        clk,
  input  logic                        clearEn,
  input  logic [memPkg::WordIdxW-1:0] clearIdx,
  input  memPkg::laneCtlT             laneCtl,
  input  logic                        wrEn,
  input  logic                        rdEn,
  output logic [31:0]                 rdData
);

  // zeroed by the clear sweep after reset
  logic [31:0] mem [Depth];

  always_ff @(posedge clk) begin
    if (clearEn) begin
      // sweep has priority over the bus port
      mem[clearIdx] <= 32'h0;
    end else begin
      // only the enabled lanes are touched
      if (wrEn) begin
        for (int k = 0; k < 4; k++) begin
          if (laneCtl.byteEn[k]) begin
            mem[laneCtl.wordIdx][8*k +: 8] <= laneCtl.wdata[8*k +: 8];
          end
        end
      end
      // lane pick is left to the load unit
      if (rdEn) begin
        rdData <= mem[laneCtl.wordIdx];
      end
    end
  end

endmodule : wordRam

`default_nettype wire

// File: design/laneSteer.sv
// ======================================================================
// access decode: word index, byte enables and alignment legality
// from the size tag and the low address bits
// ======================================================================
`default_nettype none

module laneSteer (
  input  memPkg::wbReqT   wbReq,
  output memPkg::laneCtlT laneCtl,
  output logic            accessOk
);

  import memPkg::*;

  // byte offset inside the word
  logic [1:0] offset;
  logic [3:0] byteEn;
  logic       legal;

  assign offset = wbReq.adr[1:0];

  always_comb begin
    // nothing enabled unless the size decodes cleanly
    byteEn = 4'b0000;
    legal  = 1'b0;
    unique case (wbReq.size)
      sizeByte: begin
        // any offset is fine for a byte
        byteEn = 4'b0001 << offset;
        legal  = 1'b1;
      end
      sizeHalf: begin
        // adr[1] picks the upper or lower half
        byteEn = offset[1] ? 4'b1100 : 4'b0011;
        // odd address would straddle two lanes pairs
        legal  = ~offset[0];
      end
      sizeWord: begin
        byteEn = 4'b1111;
        // word must sit on a word boundary
        legal  = (offset == 2'b00);
      end
      default: begin
        // reserved size code
        byteEn = 4'b0000;
        legal  = 1'b0;
      end
    endcase
  end

  // drop the lane bits for the word index
  assign laneCtl.wordIdx = wbReq.adr[AdrW-1:2];
  // illegal accesses carry no enables at all
  assign laneCtl.byteEn  = legal ? byteEn : 4'b0000;
  // data is already lane placed by the master
  assign laneCtl.wdata   = wbReq.dat;
  assign accessOk        = legal;

endmodule : laneSteer

`default_nettype wire

// File: design/clearCounter.sv
// ======================================================================
// word address counter for the zero clear sweep after reset
// ======================================================================
`default_nettype none

module clearCounter (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        clearEn,
  output logic [memPkg::WordIdxW-1:0] clearIdx,
  output logic                        clearDone
);

  import memPkg::*;

  // index of the last word in the array
  localparam logic [WordIdxW-1:0] LastIdx = WordIdxW'(MemWords - 1);

  logic [WordIdxW-1:0] idxQ;

  // one word per cycle while the sweep is enabled
  // holds at the last word once it gets there
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idxQ <= '0;
    end else if (clearEn && !clearDone) begin
      idxQ <= idxQ + 1'b1;
    end
  end

  assign clearIdx = idxQ;

  // high in the cycle the last word is being cleared
  // FSM leaves the clear state on this edge
  assign clearDone = (idxQ == LastIdx);

endmodule : clearCounter

`default_nettype wire

// File: design/memPkg.sv
// ======================================================================
// shared sizes, access size encoding and the Wishbone request,
// response and byte lane structs of the data memory
// ======================================================================
`default_nettype none

package memPkg;

  // array geometry
  // 256 words of 32 bits, small enough for simulation
  localparam int MemWords = 256;
  localparam int WordIdxW = $clog2(MemWords);
  // byte address adds the two lane bits below the word index
  localparam int AdrW = WordIdxW + 2;

  // access size tag on the port
  // codes follow the AHB HSIZE low bits
  typedef enum logic [1:0] {
    sizeByte = 2'b00,
    sizeHalf = 2'b01,
    sizeWord = 2'b10,
    // never legal, always answered with err
    sizeRsvd = 2'b11
  } accessSizeE;

  // master side of a classic single cycle
  typedef struct packed {
    logic            cyc;
    logic            stb;
    // 1 write, 0 read
    logic            we;
    // byte address
    logic [AdrW-1:0] adr;
    accessSizeE      size;
    // write data already in its byte lanes
    logic [31:0]     dat;
  } wbReqT;

  // slave side
  typedef struct packed {
    logic        ack;
    logic        err;
    // whole addressed word, valid with ack
    logic [31:0] dat;
  } wbRspT;

  // decoded lane control toward the RAM
  typedef struct packed {
    logic [WordIdxW-1:0] wordIdx;
    // one enable per byte lane, lane k is bits 8k+7..8k
    logic [3:0]          byteEn;
    logic [31:0]         wdata;
  } laneCtlT;

endpackage : memPkg

`default_nettype wire
